// ==== l2_tlb.f ====
src/tlb_pkg.sv
src/tlb_array.sv
src/tlb_lookup.sv
src/tlb_plru.sv
src/tlb_control.sv
src/l2_tlb.sv
test/tb_clock.sv
test/l2_tlb_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module l2_tlb_tb -f l2_tlb.f

output=$(./obj_dir/Vl2_tlb_tb 2>&1 || true)
echo "$output"

grep -qx "Verification passed" <<< "$output"

// ==== src/l2_tlb.sv ====
`default_nettype none

module l2_tlb (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       flush,
	input  wire logic                       req_valid,
	output logic                            req_ready,
	input  wire logic [tlb_pkg::ASID_W-1:0] req_asid,
	input  wire logic [tlb_pkg::VPN_W-1:0]  req_vpn,
	input  wire logic [1:0]                 req_kind,
	output logic                            resp_valid,
	input  wire logic                       resp_ready,
	output logic [tlb_pkg::PPN_W-1:0]       resp_ppn,
	output logic                            resp_fault,
	output logic                            resp_d,
	output logic                            ptw_req_valid,
	input  wire logic                       ptw_req_ready,
	output tlb_pkg::tlb_key_u               ptw_req_key,
	input  wire logic                       ptw_resp_valid,
	input  wire logic [tlb_pkg::PPN_W-1:0]  ptw_resp_ppn,
	input  wire logic                       ptw_resp_v,
	input  wire logic                       ptw_resp_u,
	input  wire logic                       ptw_resp_r,
	input  wire logic                       ptw_resp_w,
	input  wire logic                       ptw_resp_x,
	input  wire logic                       ptw_resp_d
);
	import tlb_pkg::*;

	tlb_key_u                    cur_key;
	logic [1:0]                  cur_kind;
	logic [WAYS-1:0]             rd_valid, rd_u, rd_r, rd_w, rd_x, rd_d;
	logic [WAYS-1:0][TAG_W-1:0]  rd_tags;
	logic [WAYS-1:0][PPN_W-1:0]  rd_ppns;
	logic                        hit, hit_fault, hit_d;
	logic [WAY_BITS-1:0]         hit_way, victim, fill_way, touch_way;
	logic [PPN_W-1:0]            hit_ppn, fill_ppn;
	logic                        fill_en, fill_u, fill_r, fill_w, fill_x, fill_d;
	logic                        touch;

	tlb_control u_control (
		.clock, .reset, .flush,
		.req_valid, .req_ready, .req_asid, .req_vpn, .req_kind,
		.resp_valid, .resp_ready, .resp_ppn, .resp_fault, .resp_d,
		.ptw_req_valid, .ptw_req_ready, .ptw_req_key,
		.ptw_resp_valid, .ptw_resp_ppn, .ptw_resp_v, .ptw_resp_u,
		.ptw_resp_r, .ptw_resp_w, .ptw_resp_x, .ptw_resp_d,
		.hit, .hit_way, .hit_ppn, .hit_fault, .hit_d, .victim,
		.cur_key, .cur_kind,
		.fill_en, .fill_way, .fill_ppn, .fill_u, .fill_r, .fill_w, .fill_x, .fill_d,
		.touch, .touch_way
	);

	tlb_array u_array (
		.clock, .reset, .flush,
		.rd_index (cur_key.line.index),
		.rd_valid, .rd_u, .rd_r, .rd_w, .rd_x, .rd_d, .rd_tags, .rd_ppns,
		.fill_en, .fill_way,
		.fill_key (cur_key), // refill always targets the held request
		.fill_ppn, .fill_u, .fill_r, .fill_w, .fill_x, .fill_d
	);

	tlb_lookup u_lookup (
		.key     (cur_key),
		.kind    (cur_kind),
		.rd_valid, .rd_u, .rd_r, .rd_w, .rd_x, .rd_d, .rd_tags, .rd_ppns,
		.hit, .hit_way,
		.ppn     (hit_ppn),
		.fault   (hit_fault),
		.d       (hit_d)
	);

	tlb_plru u_plru (
		.clock, .reset,
		.index   (cur_key.line.index),
		.valid   (rd_valid),
		.touch, .touch_way, .victim
	);

endmodule

`default_nettype wire

// ==== src/tlb_array.sv ====
`default_nettype none

module tlb_array (
	input  wire logic                                       clock,
	input  wire logic                                       reset,
	input  wire logic                                       flush,
	input  wire logic [tlb_pkg::SET_BITS-1:0]               rd_index,
	output logic [tlb_pkg::WAYS-1:0]                        rd_valid,
	output logic [tlb_pkg::WAYS-1:0]                        rd_u,
	output logic [tlb_pkg::WAYS-1:0]                        rd_r,
	output logic [tlb_pkg::WAYS-1:0]                        rd_w,
	output logic [tlb_pkg::WAYS-1:0]                        rd_x,
	output logic [tlb_pkg::WAYS-1:0]                        rd_d,
	output logic [tlb_pkg::WAYS-1:0][tlb_pkg::TAG_W-1:0]    rd_tags,
	output logic [tlb_pkg::WAYS-1:0][tlb_pkg::PPN_W-1:0]    rd_ppns,
	input  wire logic                                       fill_en,
	input  wire logic [tlb_pkg::WAY_BITS-1:0]               fill_way,
	input  wire tlb_pkg::tlb_key_u                          fill_key,
	input  wire logic [tlb_pkg::PPN_W-1:0]                  fill_ppn,
	input  wire logic                                       fill_u,
	input  wire logic                                       fill_r,
	input  wire logic                                       fill_w,
	input  wire logic                                       fill_x,
	input  wire logic                                       fill_d
);
	import tlb_pkg::*;

	logic [WAYS-1:0]  valid_q [SETS];
	logic [TAG_W-1:0] tag_mem [WAYS][SETS];
	logic [PPN_W-1:0] ppn_mem [WAYS][SETS];
	logic [4:0]       flag_mem [WAYS][SETS]; // u r w x d

	logic [SET_BITS-1:0] fill_idx;

	assign fill_idx = fill_key.line.index;

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else if (fill_en) begin
			valid_q[fill_idx][fill_way] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fill_en) begin
			tag_mem[fill_way][fill_idx]  <= fill_key.line.tag;
			ppn_mem[fill_way][fill_idx]  <= fill_ppn;
			flag_mem[fill_way][fill_idx] <= {fill_u, fill_r, fill_w, fill_x, fill_d};
		end
	end

	// whole set visible in the same cycle
	always_comb begin
		for (int i = 0; i < WAYS; i++) begin
			rd_valid[i] = valid_q[rd_index][i];
			rd_tags[i]  = tag_mem[i][rd_index];
			rd_ppns[i]  = ppn_mem[i][rd_index];
			{rd_u[i], rd_r[i], rd_w[i], rd_x[i], rd_d[i]} = flag_mem[i][rd_index];
		end
	end

	// control drops a walk result that meets a flush
	assert property (@(posedge clock) disable iff (reset) !(fill_en && flush))
		else $error("fill and flush on the same edge");

endmodule

`default_nettype wire

// ==== src/tlb_control.sv ====
`default_nettype none

module tlb_control (
	input  wire logic                         clock,
	input  wire logic                         reset,
	input  wire logic                         flush,
	input  wire logic                         req_valid,
	output logic                              req_ready,
	input  wire logic [tlb_pkg::ASID_W-1:0]   req_asid,
	input  wire logic [tlb_pkg::VPN_W-1:0]    req_vpn,
	input  wire logic [1:0]                   req_kind,
	output logic                              resp_valid,
	input  wire logic                         resp_ready,
	output logic [tlb_pkg::PPN_W-1:0]         resp_ppn,
	output logic                              resp_fault,
	output logic                              resp_d,
	output logic                              ptw_req_valid,
	input  wire logic                         ptw_req_ready,
	output tlb_pkg::tlb_key_u                 ptw_req_key,
	input  wire logic                         ptw_resp_valid,
	input  wire logic [tlb_pkg::PPN_W-1:0]    ptw_resp_ppn,
	input  wire logic                         ptw_resp_v,
	input  wire logic                         ptw_resp_u,
	input  wire logic                         ptw_resp_r,
	input  wire logic                         ptw_resp_w,
	input  wire logic                         ptw_resp_x,
	input  wire logic                         ptw_resp_d,
	input  wire logic                         hit,
	input  wire logic [tlb_pkg::WAY_BITS-1:0] hit_way,
	input  wire logic [tlb_pkg::PPN_W-1:0]    hit_ppn,
	input  wire logic                         hit_fault,
	input  wire logic                         hit_d,
	input  wire logic [tlb_pkg::WAY_BITS-1:0] victim,
	output tlb_pkg::tlb_key_u                 cur_key,
	output logic [1:0]                        cur_kind,
	output logic                              fill_en,
	output logic [tlb_pkg::WAY_BITS-1:0]      fill_way,
	output logic [tlb_pkg::PPN_W-1:0]         fill_ppn,
	output logic                              fill_u,
	output logic                              fill_r,
	output logic                              fill_w,
	output logic                              fill_x,
	output logic                              fill_d,
	output logic                              touch,
	output logic [tlb_pkg::WAY_BITS-1:0]      touch_way
);
	import tlb_pkg::*;

	logic [1:0]          state;
	logic                settle_q; // key registered, set read settling
	logic                look_q;   // lookup result valid this cycle
	logic [WAY_BITS-1:0] victim_q;
	logic                accept;
	logic                hit_done;
	logic                walk_done;

	assign req_ready = (state == S_READY) && !resp_valid && !settle_q && !look_q;
	assign accept    = req_valid && req_ready;
	assign hit_done  = look_q && hit;
	assign walk_done = (state == S_WAIT) && ptw_resp_valid && !flush; // flush discards it

	assign ptw_req_valid = (state == S_REQUEST);
	assign ptw_req_key   = cur_key;

	assign fill_en  = walk_done && ptw_resp_v; // invalid PTE is never cached
	assign fill_way = victim_q;
	assign fill_ppn = ptw_resp_ppn;
	assign fill_u   = ptw_resp_u;
	assign fill_r   = ptw_resp_r;
	assign fill_w   = ptw_resp_w;
	assign fill_x   = ptw_resp_x;
	assign fill_d   = ptw_resp_d;

	assign touch     = hit_done || fill_en;
	assign touch_way = fill_en ? victim_q : hit_way;

	always_ff @(posedge clock) begin
		if (reset) begin
			settle_q <= 1'b0;
			look_q   <= 1'b0;
		end else begin
			settle_q <= accept;
			look_q   <= settle_q;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			cur_key.va.asid <= req_asid;
			cur_key.va.vpn  <= req_vpn;
			cur_kind        <= req_kind;
		end
		if (look_q && !hit) begin
			victim_q <= victim;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_READY;
		end else begin
			case (state)
				S_READY: begin
					if (look_q && !hit) state <= S_REQUEST;
				end
				S_REQUEST: begin
					// a flush before the handshake leaves nothing stale to redo
					if (ptw_req_ready) state <= flush ? S_WAIT_INV : S_WAIT;
				end
				S_WAIT: begin
					if (flush) begin
						state <= ptw_resp_valid ? S_REQUEST : S_WAIT_INV; // stale reply already here
					end else if (ptw_resp_valid) begin
						state <= S_READY;
					end
				end
				default: begin
					if (ptw_resp_valid) state <= S_REQUEST; // walk again
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			resp_valid <= 1'b0;
		end else if (hit_done || walk_done) begin
			resp_valid <= 1'b1;
		end else if (resp_ready) begin
			resp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (hit_done) begin
			resp_ppn   <= hit_ppn;
			resp_fault <= hit_fault;
			resp_d     <= hit_d;
		end else if (walk_done) begin
			resp_ppn   <= ptw_resp_ppn;
			resp_fault <= !ptw_resp_v ||
				kind_fault(cur_kind, ptw_resp_r, ptw_resp_w, ptw_resp_x);
			resp_d     <= ptw_resp_d;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		ptw_req_valid && !ptw_req_ready |=> ptw_req_valid && $stable(ptw_req_key))
		else $error("PTW request dropped before ready");

	assert property (@(posedge clock) disable iff (reset)
		fill_en |-> state == S_WAIT ##1 (state == S_READY && resp_valid))
		else $error("fill outside a walk return");

endmodule

`default_nettype wire

// ==== src/tlb_lookup.sv ====
`default_nettype none

module tlb_lookup (
	input  wire tlb_pkg::tlb_key_u                          key,
	input  wire logic [1:0]                                 kind,
	input  wire logic [tlb_pkg::WAYS-1:0]                   rd_valid,
	input  wire logic [tlb_pkg::WAYS-1:0]                   rd_u,
	input  wire logic [tlb_pkg::WAYS-1:0]                   rd_r,
	input  wire logic [tlb_pkg::WAYS-1:0]                   rd_w,
	input  wire logic [tlb_pkg::WAYS-1:0]                   rd_x,
	input  wire logic [tlb_pkg::WAYS-1:0]                   rd_d,
	input  wire logic [tlb_pkg::WAYS-1:0][tlb_pkg::TAG_W-1:0] rd_tags,
	input  wire logic [tlb_pkg::WAYS-1:0][tlb_pkg::PPN_W-1:0] rd_ppns,
	output logic                                            hit,
	output logic [tlb_pkg::WAY_BITS-1:0]                    hit_way,
	output logic [tlb_pkg::PPN_W-1:0]                       ppn,
	output logic                                            fault,
	output logic                                            d
);
	import tlb_pkg::*;

	logic [WAYS-1:0] hit_vec;
	logic            sel_r;
	logic            sel_w;
	logic            sel_x;

	always_comb begin
		for (int i = 0; i < WAYS; i++) begin
			hit_vec[i] = rd_valid[i] && (rd_tags[i] == key.line.tag);
		end
	end

	assign hit = |hit_vec;

	always_comb begin
		hit_way = '0;
		ppn     = '0;
		sel_r   = 1'b0;
		sel_w   = 1'b0;
		sel_x   = 1'b0;
		d       = 1'b0;
		for (int i = 0; i < WAYS; i++) begin
			if (hit_vec[i]) begin
				hit_way = WAY_BITS'(i);
				ppn     = rd_ppns[i];
				sel_r   = rd_r[i];
				sel_w   = rd_w[i];
				sel_x   = rd_x[i];
				d       = rd_d[i];
			end
		end
	end

	assign fault = hit && kind_fault(kind, sel_r, sel_w, sel_x);

	// a refill never duplicates a tag
	always_comb begin
		assert ($onehot0(hit_vec)) else $error("more than one way hits");
	end

endmodule

`default_nettype wire

// ==== src/tlb_pkg.sv ====
`default_nettype none

package tlb_pkg;

	localparam int ASID_W   = 7;
	localparam int VPN_W    = 27;
	localparam int PPN_W    = 20;
	localparam int SET_BITS = 6;
	localparam int SETS     = 1 << SET_BITS;
	localparam int WAYS     = 4;
	localparam int WAY_BITS = 2;
	localparam int KEY_W    = ASID_W + VPN_W;
	localparam int TAG_W    = KEY_W - SET_BITS;

	// one lookup word, seen by the requester as asid/vpn and by the array as tag/index
	typedef union packed {
		struct packed {
			logic [ASID_W-1:0] asid;
			logic [VPN_W-1:0]  vpn;
		} va;
		struct packed {
			logic [TAG_W-1:0]    tag;
			logic [SET_BITS-1:0] index;
		} line;
	} tlb_key_u;

	localparam logic [1:0] ACC_LOAD  = 2'd0;
	localparam logic [1:0] ACC_STORE = 2'd1;
	localparam logic [1:0] ACC_FETCH = 2'd2;

	localparam logic [1:0] S_READY    = 2'd0;
	localparam logic [1:0] S_REQUEST  = 2'd1;
	localparam logic [1:0] S_WAIT     = 2'd2;
	localparam logic [1:0] S_WAIT_INV = 2'd3;

	// missing permission for the access kind
	function automatic logic kind_fault(input logic [1:0] kind, input logic r,
			input logic w, input logic x);
		case (kind)
			ACC_LOAD:  kind_fault = !r;
			ACC_STORE: kind_fault = !w;
			ACC_FETCH: kind_fault = !x;
			default:   kind_fault = 1'b1; // undefined kind
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== src/tlb_plru.sv ====
`default_nettype none

module tlb_plru (
	input  wire logic                         clock,
	input  wire logic                         reset,
	input  wire logic [tlb_pkg::SET_BITS-1:0] index,
	input  wire logic [tlb_pkg::WAYS-1:0]     valid,
	input  wire logic                         touch,
	input  wire logic [tlb_pkg::WAY_BITS-1:0] touch_way,
	output logic [tlb_pkg::WAY_BITS-1:0]      victim
);
	import tlb_pkg::*;

	// bit0 half, bit1 inside ways 0-1, bit2 inside ways 2-3
	logic [2:0] tree_q [SETS];
	logic [2:0] cur;
	logic [WAY_BITS-1:0] tree_way;

	assign cur = tree_q[index];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < SETS; s++) begin
				tree_q[s] <= '0;
			end
		end else if (touch) begin
			tree_q[index][0] <= ~touch_way[1]; // point at the other half
			if (touch_way[1]) begin
				tree_q[index][2] <= ~touch_way[0];
			end else begin
				tree_q[index][1] <= ~touch_way[0];
			end
		end
	end

	assign tree_way = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

	// an empty way wins over the tree, lowest first
	always_comb begin
		victim = tree_way;
		for (int i = WAYS - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				victim = WAY_BITS'(i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/l2_tlb_stim.txt ====
# op: 0 request, 1 flush, 2 request with a flush during its walk; kind: 0 load, 1 store, 2 fetch
# op asid vpn kind, pte ppn v u r w x d, expected walks fault ppn d (all hex)
0 01 0000100 0 0a001 1 1 1 1 0 1 1 0 0a001 1
0 01 0000100 0 00000 0 0 0 0 0 0 0 0 0a001 1
0 01 0000100 2 00000 0 0 0 0 0 0 0 1 0a001 1
0 01 0000100 1 00000 0 0 0 0 0 0 0 0 0a001 1
0 02 0000100 0 0b002 1 0 1 0 1 0 1 0 0b002 0
0 02 0000100 1 00000 0 0 0 0 0 0 0 1 0b002 0
0 01 0000100 0 00000 0 0 0 0 0 0 0 0 0a001 1
0 03 0000241 0 0c003 1 0 0 1 1 0 1 1 0c003 0
0 03 0000241 2 00000 0 0 0 0 0 0 0 0 0c003 0
0 03 0000382 0 0d004 0 1 1 1 1 1 1 1 0d004 1
0 03 0000382 0 0d005 1 1 1 1 1 0 1 0 0d005 0
0 03 0000382 0 00000 0 0 0 0 0 0 0 0 0d005 0
0 04 0000045 0 10001 1 1 1 1 1 0 1 0 10001 0
0 04 0000085 0 10002 1 1 1 1 1 0 1 0 10002 0
0 04 00000c5 0 10003 1 1 1 1 1 0 1 0 10003 0
0 04 0000105 0 10004 1 1 1 1 1 0 1 0 10004 0
0 04 0000045 0 00000 0 0 0 0 0 0 0 0 10001 0
0 04 0000085 0 00000 0 0 0 0 0 0 0 0 10002 0
0 04 0000145 0 10005 1 1 1 1 1 0 1 0 10005 0
0 04 00000c5 0 10013 1 1 1 1 1 0 1 0 10013 0
0 04 0000085 0 00000 0 0 0 0 0 0 0 0 10002 0
0 04 0000105 0 00000 0 0 0 0 0 0 0 0 10004 0
0 04 0000145 0 00000 0 0 0 0 0 0 0 0 10005 0
1 00 0000000 0 00000 0 0 0 0 0 0 0 0 00000 0
0 01 0000100 0 0a011 1 1 1 1 0 1 1 0 0a011 1
2 04 0000145 0 10025 1 1 1 1 1 0 2 0 10025 0
0 01 0000100 0 0a021 1 1 1 1 0 1 1 0 0a021 1
0 04 0000145 0 00000 0 0 0 0 0 0 0 0 10025 0

// ==== test/l2_tlb_tb.sv ====
`default_nettype none

module l2_tlb_tb;
	import tlb_pkg::*;

	localparam int WAIT_LIMIT = 200;

	logic              clock;
	logic              reset;
	logic              flush;
	logic              req_valid;
	logic              req_ready;
	logic [ASID_W-1:0] req_asid;
	logic [VPN_W-1:0]  req_vpn;
	logic [1:0]        req_kind;
	logic              resp_valid;
	logic              resp_ready;
	logic [PPN_W-1:0]  resp_ppn;
	logic              resp_fault;
	logic              resp_d;
	logic              ptw_req_valid;
	logic              ptw_req_ready;
	tlb_key_u          ptw_req_key;
	logic              ptw_resp_valid;
	logic [PPN_W-1:0]  ptw_resp_ppn;
	logic              ptw_resp_v, ptw_resp_u, ptw_resp_r, ptw_resp_w, ptw_resp_x, ptw_resp_d;

	// one stimulus line
	logic [31:0] stim_op, stim_asid, stim_vpn, stim_kind;
	logic [31:0] pte_ppn, pte_v, pte_u, pte_r, pte_w, pte_x, pte_d;
	logic [31:0] exp_walks, exp_fault, exp_ppn, exp_d;

	logic [31:0] rng_state;

	tb_clock clock_gen (
		.clock,
		.reset
	);

	l2_tlb UUT (
		.clock, .reset, .flush,
		.req_valid, .req_ready, .req_asid, .req_vpn, .req_kind,
		.resp_valid, .resp_ready, .resp_ppn, .resp_fault, .resp_d,
		.ptw_req_valid, .ptw_req_ready, .ptw_req_key,
		.ptw_resp_valid, .ptw_resp_ppn, .ptw_resp_v, .ptw_resp_u,
		.ptw_resp_r, .ptw_resp_w, .ptw_resp_x, .ptw_resp_d
	);

	// lcg, value in 0..n-1
	function automatic int unsigned roll(input int unsigned n);
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return (rng_state >> 16) % n;
	endfunction

	task automatic abort_run;
		$display("Verification failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		abort_run();
	endtask

	task automatic check_key(input string name, input tlb_key_u got, input tlb_key_u want);
		if (got !== want) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_ppn(input string name, input logic [PPN_W-1:0] got,
			input logic [PPN_W-1:0] want);
		if (got !== want) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic pulse_flush;
		@(posedge clock);
		flush <= 1'b1;
		@(posedge clock);
		flush <= 1'b0;
	endtask

	// one request, with the PTW model running alongside until the response is taken
	task automatic run_request(input logic flush_mid_walk);
		tlb_key_u         want_key;
		int unsigned      waited;
		int unsigned      edges;
		int unsigned      walks;
		int unsigned      rdy_cnt;
		int unsigned      answer_cnt;
		int unsigned      reply_at;
		logic             pending;
		logic             busy;
		logic             fresh;
		logic             seen;
		logic             done;
		logic [PPN_W-1:0] held_ppn;
		logic             held_fault;
		logic             held_d;
		logic             nx_ready;
		logic             nx_resp;
		logic             nx_flush;
		logic [PPN_W-1:0] nx_ppn;

		want_key.va.asid = ASID_W'(stim_asid);
		want_key.va.vpn  = VPN_W'(stim_vpn);
		@(posedge clock);
		req_valid <= 1'b1;
		req_asid  <= ASID_W'(stim_asid);
		req_vpn   <= VPN_W'(stim_vpn);
		req_kind  <= stim_kind[1:0];
		waited = 0;
		@(negedge clock);
		while (!req_ready) begin
			waited++;
			if (waited > WAIT_LIMIT) report_timeout("req_ready");
			@(negedge clock);
		end
		@(posedge clock); // accepting edge
		req_valid <= 1'b0;

		edges = 0;
		walks = 0;
		rdy_cnt = 0;
		answer_cnt = 0;
		reply_at = 0;
		pending = 1'b0;
		busy = 1'b0;
		fresh = 1'b0;
		seen = 1'b0;
		done = 1'b0;
		while (!done) begin
			@(negedge clock);
			nx_ready = ptw_req_ready;
			nx_resp  = 1'b0;
			nx_flush = 1'b0;
			nx_ppn   = PPN_W'(pte_ppn);
			if (busy) begin
				if (fresh && flush_mid_walk && walks == 1) nx_flush = 1'b1;
				fresh = 1'b0;
				answer_cnt--;
				if (answer_cnt == 0) begin
					busy = 1'b0;
					nx_resp = 1'b1;
					reply_at = edges + 2;
					if (flush_mid_walk && walks == 1) nx_ppn = PPN_W'(pte_ppn) ^ '1; // decoy
				end
			end
			if (ptw_req_valid && ptw_req_ready) begin
				nx_ready = 1'b0; // handshake on the coming edge
				pending = 1'b0;
				busy = 1'b1;
				fresh = 1'b1;
				answer_cnt = (flush_mid_walk && walks == 1) ? 2 + roll(5) : 1 + roll(6);
			end else if (ptw_req_valid) begin
				if (!pending) begin
					pending = 1'b1;
					walks++;
					check_key("ptw_req_key", ptw_req_key, want_key);
					rdy_cnt = roll(4);
				end
				if (rdy_cnt == 0) nx_ready = 1'b1;
				else rdy_cnt--;
			end

			if (resp_valid) begin
				if (!seen) begin
					seen = 1'b1;
					check_flag("walked", walks != 0, exp_walks != 0);
					check_flag("walked twice", walks > 1, exp_walks > 1);
					check_flag("walked more than twice", walks > 2, exp_walks > 2);
					if (walks == 0) check_flag("hit two edges after accept", edges == 2, 1'b1);
					else check_flag("response one edge after PTW reply", edges == reply_at, 1'b1);
					check_ppn("resp_ppn", resp_ppn, PPN_W'(exp_ppn));
					check_flag("resp_fault", resp_fault, exp_fault[0]);
					check_flag("resp_d", resp_d, exp_d[0]);
					held_ppn = resp_ppn;
					held_fault = resp_fault;
					held_d = resp_d;
				end else begin
					check_ppn("held resp_ppn", resp_ppn, held_ppn);
					check_flag("held resp_fault", resp_fault, held_fault);
					check_flag("held resp_d", resp_d, held_d);
				end
				check_flag("req_ready while response pending", req_ready, 1'b0);
				if (resp_ready) done = 1'b1;
			end

			@(posedge clock);
			ptw_req_ready  <= nx_ready;
			ptw_resp_valid <= nx_resp;
			ptw_resp_ppn   <= nx_ppn;
			ptw_resp_v     <= pte_v[0];
			ptw_resp_u     <= pte_u[0];
			ptw_resp_r     <= pte_r[0];
			ptw_resp_w     <= pte_w[0];
			ptw_resp_x     <= pte_x[0];
			ptw_resp_d     <= pte_d[0];
			flush          <= nx_flush;
			resp_ready     <= (roll(3) != 0); // stalls about a third of the cycles
			edges++;
			if (edges > WAIT_LIMIT) report_timeout("the TLB response");
		end
	endtask

	initial begin
		int    fd;
		int    fields;
		int    waited;
		int    lines_run;
		string line;

		rng_state = 32'd71600;
		flush = 1'b0;
		req_valid = 1'b0;
		req_asid = '0;
		req_vpn = '0;
		req_kind = ACC_LOAD;
		resp_ready = 1'b1;
		ptw_req_ready = 1'b0;
		ptw_resp_valid = 1'b0;
		ptw_resp_ppn = '0;
		ptw_resp_v = 1'b0;
		ptw_resp_u = 1'b0;
		ptw_resp_r = 1'b0;
		ptw_resp_w = 1'b0;
		ptw_resp_x = 1'b0;
		ptw_resp_d = 1'b0;
		lines_run = 0;

		fd = $fopen("test/l2_tlb_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file");
			abort_run();
		end

		waited = 0;
		@(negedge clock);
		while (reset) begin
			waited++;
			if (waited > WAIT_LIMIT) report_timeout("reset release");
			@(negedge clock);
		end
		check_flag("req_ready after reset", req_ready, 1'b1);
		check_flag("resp_valid after reset", resp_valid, 1'b0);
		check_flag("ptw_req_valid after reset", ptw_req_valid, 1'b0);

		while (!$feof(fd)) begin
			if ($fgets(line, fd) == 0) break;
			if (line.len() < 2 || line.getc(0) == "#") continue;
			fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				stim_op, stim_asid, stim_vpn, stim_kind, pte_ppn, pte_v, pte_u,
				pte_r, pte_w, pte_x, pte_d, exp_walks, exp_fault, exp_ppn, exp_d);
			if (fields != 15) begin
				$display("malformed stimulus line: %s", line);
				abort_run();
			end
			case (stim_op)
				0: run_request(1'b0);
				1: pulse_flush();
				2: run_request(1'b1); // flush lands during the walk
				default: begin
					$display("unknown operation %0d in the stimulus file", stim_op);
					abort_run();
				end
			endcase
			lines_run++;
		end
		$fclose(fd);

		if (lines_run == 0) begin
			$display("the stimulus file holds no operations");
			abort_run();
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // period 20
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire
